// File: rtl/rs_settings.svh
`ifndef RS_SETTINGS_SVH
`define RS_SETTINGS_SVH

// tag and index widths
`define RS_PREG_BITS 6  // physical register tag
`define RS_AREG_BITS 5  // architectural dest index, x0..x31
`define RS_ROB_BITS  6  // reorder buffer slot

// opcode field carried with each entry
`define RS_OP_BITS   3

// entries per station
`define RS_ADD_DEPTH 4
`define RS_MUL_DEPTH 4

`endif

// File: rtl/rs_pkg.sv
`default_nettype none

`include "rs_settings.svh"

package rs_pkg;

    typedef logic [`RS_PREG_BITS-1:0] preg_t;    // physical tag
    typedef logic [`RS_AREG_BITS-1:0] areg_t;    // arch dest
    typedef logic [`RS_ROB_BITS-1:0]  rob_idx_t; // rob slot

    // alu ops first, then the multiplier ops
    typedef enum logic [`RS_OP_BITS-1:0] {
        OP_ADD   = 3'd0,
        OP_SUB   = 3'd1,
        OP_AND   = 3'd2,
        OP_OR    = 3'd3,
        OP_XOR   = 3'd4,
        OP_MUL   = 3'd5,
        OP_MULH  = 3'd6,
        OP_MULHU = 3'd7
    } fu_op_e;

    // which station a dispatch targets
    typedef enum logic {
        RS_ADD = 1'b0,
        RS_MUL = 1'b1
    } rs_sel_e;

    // one station slot
    typedef struct packed {
        logic     busy;     // slot holds a live instruction
        preg_t    ps1;
        logic     ps1_rdy;  // source 1 value available
        preg_t    ps2;
        logic     ps2_rdy;
        preg_t    pd;       // dest tag, goes out on issue
        areg_t    rd;
        rob_idx_t rob;
        fu_op_e   op;
    } rs_entry_t;

endpackage : rs_pkg

`default_nettype wire

// File: rtl/issue_select.sv
`default_nettype none

`include "rs_settings.svh"

// lowest-index ready entry wins, one pick per cycle
module issue_select #(
    parameter int DEPTH = `RS_ADD_DEPTH,
    localparam int IDX_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  rs_pkg::rs_entry_t    entries [DEPTH],
    input  logic                 fu_busy,       // unit cannot take an op this cycle
    output logic                 issue_valid,
    output logic [IDX_BITS-1:0]  issue_idx,
    output rs_pkg::rs_entry_t    issue_entry
);

    import rs_pkg::*;

    // live and both sources present
    function automatic logic can_issue(input rs_entry_t e);
        return e.busy && e.ps1_rdy && e.ps2_rdy;
    endfunction

    always_comb
    begin
        issue_valid = 1'b0;
        issue_idx   = '0;
        issue_entry = '0;   // zeros when idle
        if (!fu_busy)
        begin
            // walk downward, last hit is the lowest index
            for (int i = DEPTH - 1; i >= 0; i--)
            begin
                if (can_issue(entries[i]))
                begin
                    issue_valid = 1'b1;
                    issue_idx   = IDX_BITS'(i);
                    issue_entry = entries[i];
                end
            end
        end
    end

endmodule : issue_select

`default_nettype wire

// File: rtl/rs_bank.sv
`default_nettype none

`include "rs_settings.svh"

// one reservation station feeding one functional unit
module rs_bank #(
    parameter int             DEPTH    = `RS_ADD_DEPTH,
    parameter rs_pkg::rs_sel_e BANK_SEL = rs_pkg::RS_ADD,
    localparam int            IDX_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic               clk,
    input  logic               rst,

    input  logic               dispatch_valid,
    input  rs_pkg::rs_sel_e    dispatch_sel,    // only our code is taken
    input  rs_pkg::preg_t      ps1,
    input  logic               ps1_rdy,
    input  rs_pkg::preg_t      ps2,
    input  logic               ps2_rdy,
    input  rs_pkg::preg_t      pd,
    input  rs_pkg::areg_t      rd,
    input  rs_pkg::rob_idx_t   rob,
    input  rs_pkg::fu_op_e     op,

    input  logic               cdb_add_valid,
    input  rs_pkg::preg_t      cdb_add_tag,
    input  logic               cdb_mul_valid,
    input  rs_pkg::preg_t      cdb_mul_tag,

    input  logic               fu_busy,

    output logic               full,
    output logic               issue_valid,
    output rs_pkg::preg_t      issue_ps1,
    output rs_pkg::preg_t      issue_ps2,
    output rs_pkg::preg_t      issue_pd,
    output rs_pkg::areg_t      issue_rd,
    output rs_pkg::rob_idx_t   issue_rob,
    output rs_pkg::fu_op_e     issue_op
);

    import rs_pkg::*;

    rs_entry_t entries_q [DEPTH];   // station storage

    // broadcasts delayed one cycle before they touch stored entries
    logic  cdb_add_valid_q;
    preg_t cdb_add_tag_q;
    logic  cdb_mul_valid_q;
    preg_t cdb_mul_tag_q;

    logic [IDX_BITS-1:0] free_idx;      // lowest idle slot
    logic                take;          // dispatch written this edge
    rs_entry_t           new_entry;

    logic                sel_valid;
    logic [IDX_BITS-1:0] sel_idx;
    rs_entry_t           sel_entry;

    // true when either bus carries a valid tag equal to src
    function automatic logic tag_hit(
        input preg_t src,
        input logic  add_v,
        input preg_t add_t,
        input logic  mul_v,
        input preg_t mul_t
    );
        return (add_v && add_t == src) || (mul_v && mul_t == src);
    endfunction

    // free slot search and full flag from current state only
    always_comb
    begin
        free_idx   = '0;
        full       = 1'b1;
        for (int i = DEPTH - 1; i >= 0; i--)
        begin
            if (!entries_q[i].busy)
            begin
                free_idx   = IDX_BITS'(i);  // keeps overwriting down to lowest
                full       = 1'b0;
            end
        end
    end

    assign take = dispatch_valid && (dispatch_sel == BANK_SEL) && !full;

    // a same-cycle broadcast marks an incoming source ready
    always_comb
    begin
        new_entry.busy    = 1'b1;
        new_entry.ps1     = ps1;
        new_entry.ps1_rdy = ps1_rdy
                            || tag_hit(ps1, cdb_add_valid, cdb_add_tag,
                                       cdb_mul_valid, cdb_mul_tag);
        new_entry.ps2     = ps2;
        new_entry.ps2_rdy = ps2_rdy
                            || tag_hit(ps2, cdb_add_valid, cdb_add_tag,
                                       cdb_mul_valid, cdb_mul_tag);
        new_entry.pd      = pd;
        new_entry.rd      = rd;
        new_entry.rob     = rob;
        new_entry.op      = op;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cdb_add_valid_q <= 1'b0;
            cdb_add_tag_q   <= '0;
            cdb_mul_valid_q <= 1'b0;
            cdb_mul_tag_q   <= '0;
        end
        else
        begin
            cdb_add_valid_q <= cdb_add_valid;
            cdb_add_tag_q   <= cdb_add_tag;
            cdb_mul_valid_q <= cdb_mul_valid;
            cdb_mul_tag_q   <= cdb_mul_tag;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < DEPTH; i++)
            begin
                entries_q[i] <= '0;
            end
        end
        else
        begin
            // wakeup from last cycle's broadcasts
            for (int i = 0; i < DEPTH; i++)
            begin
                if (entries_q[i].busy
                    && tag_hit(entries_q[i].ps1, cdb_add_valid_q, cdb_add_tag_q,
                               cdb_mul_valid_q, cdb_mul_tag_q))
                begin
                    entries_q[i].ps1_rdy <= 1'b1;
                end
                if (entries_q[i].busy
                    && tag_hit(entries_q[i].ps2, cdb_add_valid_q, cdb_add_tag_q,
                               cdb_mul_valid_q, cdb_mul_tag_q))
                begin
                    entries_q[i].ps2_rdy <= 1'b1;
                end
            end
            if (sel_valid)
            begin
                entries_q[sel_idx].busy <= 1'b0;    // handed to the unit
            end
            // free_idx never names the issuing slot since that one is still busy
            if (take)
            begin
                entries_q[free_idx] <= new_entry;
            end
        end
    end

    issue_select #(
        .DEPTH       (DEPTH)
    ) u_select (
        .entries     (entries_q),
        .fu_busy     (fu_busy),
        .issue_valid (sel_valid),
        .issue_idx   (sel_idx),
        .issue_entry (sel_entry)
    );

    assign issue_valid = sel_valid;
    assign issue_ps1   = sel_entry.ps1;
    assign issue_ps2   = sel_entry.ps2;
    assign issue_pd    = sel_entry.pd;
    assign issue_rd    = sel_entry.rd;
    assign issue_rob   = sel_entry.rob;
    assign issue_op    = sel_entry.op;

    // dispatcher must watch full before targeting this station
    a_no_dispatch_full: assert property (@(posedge clk) disable iff (rst)
        (dispatch_valid && dispatch_sel == BANK_SEL) |-> !full);

    // picked slot is live now and free after the edge
    a_issue_busy: assert property (@(posedge clk) disable iff (rst)
        sel_valid |-> entries_q[sel_idx].busy ##1 !entries_q[$past(sel_idx)].busy);

    // room reported means the write slot really is idle
    a_full_no_free: assert property (@(posedge clk) disable iff (rst)
        !full |-> !entries_q[free_idx].busy);

endmodule : rs_bank

`default_nettype wire

// File: rtl/rs_top.sv
`default_nettype none

`include "rs_settings.svh"

// adder and multiplier stations side by side, shared dispatch and broadcasts
module rs_top (
    input  logic               clk,
    input  logic               rst,

    // dispatch, fanned to both stations
    input  logic               dispatch_valid,
    input  rs_pkg::rs_sel_e    dispatch_sel,
    input  rs_pkg::preg_t      ps1,
    input  logic               ps1_rdy,
    input  rs_pkg::preg_t      ps2,
    input  logic               ps2_rdy,
    input  rs_pkg::preg_t      pd,
    input  rs_pkg::areg_t      rd,
    input  rs_pkg::rob_idx_t   rob,
    input  rs_pkg::fu_op_e     op,

    // completion buses
    input  logic               cdb_add_valid,
    input  rs_pkg::preg_t      cdb_add_tag,
    input  logic               cdb_mul_valid,
    input  rs_pkg::preg_t      cdb_mul_tag,

    input  logic               add_fu_busy,
    input  logic               mul_fu_busy,

    output logic               add_full,
    output logic               mul_full,

    // adder issue
    output logic               add_issue_valid,
    output rs_pkg::preg_t      add_ps1,
    output rs_pkg::preg_t      add_ps2,
    output rs_pkg::preg_t      add_pd,
    output rs_pkg::areg_t      add_rd,
    output rs_pkg::rob_idx_t   add_rob,
    output rs_pkg::fu_op_e     add_op,

    // multiplier issue
    output logic               mul_issue_valid,
    output rs_pkg::preg_t      mul_ps1,
    output rs_pkg::preg_t      mul_ps2,
    output rs_pkg::preg_t      mul_pd,
    output rs_pkg::areg_t      mul_rd,
    output rs_pkg::rob_idx_t   mul_rob,
    output rs_pkg::fu_op_e     mul_op
);

    import rs_pkg::*;

    rs_bank #(
        .DEPTH          (`RS_ADD_DEPTH),
        .BANK_SEL       (RS_ADD)
    ) u_add_rs (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_sel   (dispatch_sel),
        .ps1            (ps1),
        .ps1_rdy        (ps1_rdy),
        .ps2            (ps2),
        .ps2_rdy        (ps2_rdy),
        .pd             (pd),
        .rd             (rd),
        .rob            (rob),
        .op             (op),
        .cdb_add_valid  (cdb_add_valid),
        .cdb_add_tag    (cdb_add_tag),
        .cdb_mul_valid  (cdb_mul_valid),
        .cdb_mul_tag    (cdb_mul_tag),
        .fu_busy        (add_fu_busy),
        .full           (add_full),
        .issue_valid    (add_issue_valid),
        .issue_ps1      (add_ps1),
        .issue_ps2      (add_ps2),
        .issue_pd       (add_pd),
        .issue_rd       (add_rd),
        .issue_rob      (add_rob),
        .issue_op       (add_op)
    );

    rs_bank #(
        .DEPTH          (`RS_MUL_DEPTH),
        .BANK_SEL       (RS_MUL)
    ) u_mul_rs (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_sel   (dispatch_sel),
        .ps1            (ps1),
        .ps1_rdy        (ps1_rdy),
        .ps2            (ps2),
        .ps2_rdy        (ps2_rdy),
        .pd             (pd),
        .rd             (rd),
        .rob            (rob),
        .op             (op),
        .cdb_add_valid  (cdb_add_valid),
        .cdb_add_tag    (cdb_add_tag),
        .cdb_mul_valid  (cdb_mul_valid),
        .cdb_mul_tag    (cdb_mul_tag),
        .fu_busy        (mul_fu_busy),
        .full           (mul_full),
        .issue_valid    (mul_issue_valid),
        .issue_ps1      (mul_ps1),
        .issue_ps2      (mul_ps2),
        .issue_pd       (mul_pd),
        .issue_rd       (mul_rd),
        .issue_rob      (mul_rob),
        .issue_op       (mul_op)
    );

endmodule : rs_top

`default_nettype wire

// File: bench/tb_clock.sv
`default_nettype none

// free-running clock plus a synchronous reset pulse
module tb_clock #(
    parameter int PERIOD_NS  = 40,
    parameter int RST_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 1ps;

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial
    begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #2 rst = 1'b0;  // released just after the edge, same as other inputs
    end

endmodule : tb_clock

`default_nettype wire

// File: bench/rs_tb.sv
`default_nettype none

`include "rs_settings.svh"

// directed tests for the adder and multiplier stations, every cycle checked against a model
module rs_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import rs_pkg::*;

    localparam int MAX_DEPTH   = (`RS_ADD_DEPTH > `RS_MUL_DEPTH) ? `RS_ADD_DEPTH : `RS_MUL_DEPTH;
    localparam int TEST_CYCLES = 122;               // reset plus all six tests
    localparam int LIMIT       = TEST_CYCLES * 3 / 2;
    localparam int IN_DELAY    = 2;                 // ns after the rising edge

    logic clk;
    logic rst;
    logic dispatch_valid;
    rs_sel_e dispatch_sel;
    preg_t ps1;
    logic ps1_rdy;
    preg_t ps2;
    logic ps2_rdy;
    preg_t pd;
    areg_t rd;
    rob_idx_t rob;
    fu_op_e op;
    logic cdb_add_valid;
    preg_t cdb_add_tag;
    logic cdb_mul_valid;
    preg_t cdb_mul_tag;
    logic add_fu_busy;
    logic mul_fu_busy;
    logic add_full;
    logic mul_full;
    logic add_issue_valid;
    preg_t add_ps1;
    preg_t add_ps2;
    preg_t add_pd;
    areg_t add_rd;
    rob_idx_t add_rob;
    fu_op_e add_op;
    logic mul_issue_valid;
    preg_t mul_ps1;
    preg_t mul_ps2;
    preg_t mul_pd;
    areg_t mul_rd;
    rob_idx_t mul_rob;
    fu_op_e mul_op;

    rs_entry_t m_ent [2][MAX_DEPTH];    // model, index 0 adder, 1 multiplier
    logic m_av;                         // model copy of the delayed broadcasts
    preg_t m_at;
    logic m_mv;
    preg_t m_mt;
    logic [31:0] lfsr_q;
    int errors = 0;
    int checks = 0;
    int cycles = 0;

    tb_clock #(.PERIOD_NS(40), .RST_CYCLES(8)) u_clock (.clk(clk), .rst(rst));

    rs_top i_dut (.*);

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] lfsr_take(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], lfsr_bit()};    // one step per bit
        return v;
    endfunction

    function automatic int depth_of(input int s);
        return (s == 0) ? `RS_ADD_DEPTH : `RS_MUL_DEPTH;
    endfunction

    // operand released by a valid broadcast of its tag
    function automatic logic woken(input preg_t t, input logic av, input preg_t at,
                                   input logic mv, input preg_t mt);
        return (av && at == t) || (mv && mt == t);
    endfunction

    function automatic logic model_full(input int s);
        logic f;
        f = 1'b1;
        for (int i = 0; i < depth_of(s); i++)
            if (!m_ent[s][i].busy)
                f = 1'b0;
        return f;
    endfunction

    // first entry with both sources present, -1 if none or unit busy
    function automatic int model_pick(input int s, input logic busy_fu);
        int pick;
        pick = -1;
        for (int i = 0; i < depth_of(s) && pick < 0 && !busy_fu; i++)
            if (m_ent[s][i].busy && m_ent[s][i].ps1_rdy && m_ent[s][i].ps2_rdy)
                pick = i;
        return pick;
    endfunction

    function automatic rs_entry_t model_entry(input int s, input int pick);
        rs_entry_t e;
        e = '0;     // idle station shows zeros
        if (pick >= 0)
            e = m_ent[s][pick];
        return e;
    endfunction

    // entry as written from the dispatch inputs, same-cycle broadcast counts
    function automatic rs_entry_t dispatched();
        rs_entry_t e;
        e.busy    = 1'b1;
        e.ps1     = ps1;
        e.ps1_rdy = ps1_rdy || woken(ps1, cdb_add_valid, cdb_add_tag, cdb_mul_valid, cdb_mul_tag);
        e.ps2     = ps2;
        e.ps2_rdy = ps2_rdy || woken(ps2, cdb_add_valid, cdb_add_tag, cdb_mul_valid, cdb_mul_tag);
        e.pd      = pd;
        e.rd      = rd;
        e.rob     = rob;
        e.op      = op;
        return e;
    endfunction

    task automatic report_hex(input string sig, input logic [31:0] exp, input logic [31:0] act);
        errors++;
        $display("Fail %s exp %h got %h at %0t", sig, exp, act, $time);
    endtask

    task automatic check_flag(input string sig, input logic exp, input logic act);
        checks++;
        if (act !== exp)
            report_hex(sig, 32'(exp), 32'(act));
    endtask

    task automatic check_issue(input string unit, input rs_entry_t exp, input preg_t a_ps1,
                               input preg_t a_ps2, input preg_t a_pd, input areg_t a_rd,
                               input rob_idx_t a_rob, input fu_op_e a_op);
        checks++;
        if (a_ps1 !== exp.ps1)
            report_hex({unit, "_ps1"}, 32'(exp.ps1), 32'(a_ps1));
        if (a_ps2 !== exp.ps2)
            report_hex({unit, "_ps2"}, 32'(exp.ps2), 32'(a_ps2));
        if (a_pd !== exp.pd)
            report_hex({unit, "_pd"}, 32'(exp.pd), 32'(a_pd));
        if (a_rd !== exp.rd)
            report_hex({unit, "_rd"}, 32'(exp.rd), 32'(a_rd));
        if (a_rob !== exp.rob)
            report_hex({unit, "_rob"}, 32'(exp.rob), 32'(a_rob));
        if (a_op !== exp.op)
            report_hex({unit, "_op"}, 32'(exp.op), 32'(a_op));
    endtask

    task automatic check_station(input int s, input rs_entry_t e);
        if (s == 0)
            check_issue("add", e, add_ps1, add_ps2, add_pd, add_rd, add_rob, add_op);
        else
            check_issue("mul", e, mul_ps1, mul_ps2, mul_pd, mul_rd, mul_rob, mul_op);
    endtask

    task automatic expect_valid(input int s, input logic exp);
        if (s == 0)
            check_flag("add_issue_valid", exp, add_issue_valid);
        else
            check_flag("mul_issue_valid", exp, mul_issue_valid);
    endtask

    // mid-cycle, outputs settled; whole DUT state against the model
    task automatic sample();
        int ap;
        int mp;
        @(negedge clk);
        ap = model_pick(0, add_fu_busy);
        mp = model_pick(1, mul_fu_busy);
        check_flag("add_full", model_full(0), add_full);
        check_flag("mul_full", model_full(1), mul_full);
        expect_valid(0, ap >= 0);
        expect_valid(1, mp >= 0);
        check_station(0, model_entry(0, ap));
        check_station(1, model_entry(1, mp));
    endtask

    // model takes the coming edge, then inputs may change
    task automatic advance();
        int pick;
        int slot;
        logic was_full;
        for (int s = 0; s < 2; s++)
        begin
            pick     = model_pick(s, (s == 0) ? add_fu_busy : mul_fu_busy);
            was_full = model_full(s);
            slot     = -1;
            for (int i = depth_of(s) - 1; i >= 0; i--)
                if (!m_ent[s][i].busy)
                    slot = i;       // lowest free before this edge
            for (int i = 0; i < depth_of(s); i++)
            begin
                if (m_ent[s][i].busy && woken(m_ent[s][i].ps1, m_av, m_at, m_mv, m_mt))
                    m_ent[s][i].ps1_rdy = 1'b1;
                if (m_ent[s][i].busy && woken(m_ent[s][i].ps2, m_av, m_at, m_mv, m_mt))
                    m_ent[s][i].ps2_rdy = 1'b1;
            end
            if (pick >= 0)
                m_ent[s][pick].busy = 1'b0;
            if (dispatch_valid && int'(dispatch_sel) == s && !was_full)
                m_ent[s][slot] = dispatched();
        end
        m_av = cdb_add_valid;
        m_at = cdb_add_tag;
        m_mv = cdb_mul_valid;
        m_mt = cdb_mul_tag;
        @(posedge clk);
        #(IN_DELAY);
    endtask

    task automatic tick();
        sample();
        advance();
    endtask

    task automatic idle_inputs();
        dispatch_valid = 1'b0;
        cdb_add_valid  = 1'b0;
        cdb_mul_valid  = 1'b0;
    endtask

    task automatic drive_dispatch(input rs_sel_e sel, input preg_t s1, input logic r1,
                                  input preg_t s2, input logic r2, input rob_idx_t r,
                                  input fu_op_e o);
        dispatch_valid = 1'b1;
        dispatch_sel   = sel;
        ps1            = s1;
        ps1_rdy        = r1;
        ps2            = s2;
        ps2_rdy        = r2;
        rob            = r;
        pd             = preg_t'(r) ^ 6'h2a;    // dest tag tied to rob slot
        rd             = areg_t'(r);
        op             = o;
    endtask

    task automatic drive_cdb(input logic on_mul, input logic v, input preg_t t);
        if (on_mul)
        begin
            cdb_mul_valid = v;
            cdb_mul_tag   = t;
        end
        else
        begin
            cdb_add_valid = v;
            cdb_add_tag   = t;
        end
    endtask

    task automatic test_direct_issue();
        rs_entry_t e;
        sample();
        check_flag("add_issue_valid", 1'b0, add_issue_valid);  // clean after reset
        check_flag("mul_issue_valid", 1'b0, mul_issue_valid);
        check_flag("add_full", 1'b0, add_full);
        check_flag("mul_full", 1'b0, mul_full);
        advance();
        for (int s = 0; s < 2; s++)
        begin
            drive_dispatch(rs_sel_e'(s), preg_t'(1 + s), 1'b1, preg_t'(3), 1'b1,
                           rob_idx_t'(5 + s), (s == 0) ? OP_SUB : OP_MULH);
            e = '{busy: 1'b1, ps1: ps1, ps1_rdy: 1'b1, ps2: ps2, ps2_rdy: 1'b1,
                  pd: pd, rd: rd, rob: rob, op: op};
            tick();
            idle_inputs();
            sample();
            expect_valid(s, 1'b1);  // one cycle after dispatch
            check_station(s, e);
            advance();
        end
    endtask

    task automatic test_wakeup();
        for (int s = 0; s < 2; s++)
        begin
            drive_dispatch(rs_sel_e'(s), preg_t'(10 + s), 1'b0, preg_t'(3), 1'b1,
                           rob_idx_t'(2 + s), (s == 0) ? OP_AND : OP_MUL);
            tick();
            idle_inputs();
            drive_cdb(s == 0, 1'b1, preg_t'(12));          // wrong tag
            tick();
            idle_inputs();
            drive_cdb(s == 0, 1'b0, preg_t'(10 + s));      // right tag, valid low
            tick();
            idle_inputs();
            tick();
            sample();
            expect_valid(s, 1'b0);
            advance();
            drive_cdb(s == 0, 1'b1, preg_t'(10 + s));      // crossed bus for coverage
            tick();
            idle_inputs();
            sample();
            expect_valid(s, 1'b0);  // still waiting at t+1
            advance();
            sample();
            expect_valid(s, 1'b1);
            advance();
        end
    endtask

    task automatic test_same_cycle_wakeup();
        for (int s = 0; s < 2; s++)
        begin
            drive_dispatch(rs_sel_e'(s), preg_t'(3), 1'b1, preg_t'(40 + s), 1'b0,
                           rob_idx_t'(30 + s), (s == 0) ? OP_OR : OP_MULHU);
            drive_cdb(s != 0, 1'b1, preg_t'(40 + s));
            tick();
            idle_inputs();
            sample();
            expect_valid(s, 1'b1);
            advance();
        end
    endtask

    task automatic test_fill();
        for (int i = 0; i < `RS_ADD_DEPTH; i++)
        begin
            drive_dispatch(RS_ADD, preg_t'(30 + i), 1'b0, preg_t'(3), 1'b1,
                           rob_idx_t'(8 + i), OP_XOR);
            tick();
        end
        idle_inputs();
        sample();
        check_flag("add_full", 1'b1, add_full);
        check_flag("mul_full", 1'b0, mul_full);   // other station untouched
        advance();
        drive_cdb(1'b0, 1'b1, preg_t'(30));
        tick();
        idle_inputs();
        tick();
        sample();
        expect_valid(0, 1'b1);
        check_flag("add_full", 1'b1, add_full);   // drops only after the edge
        advance();
        sample();
        check_flag("add_full", 1'b0, add_full);
        advance();
        for (int i = 1; i < `RS_ADD_DEPTH; i++)
        begin
            drive_cdb(1'b0, 1'b1, preg_t'(30 + i));
            tick();
        end
        idle_inputs();
        repeat (3) tick();
    endtask

    task automatic test_backpressure();
        add_fu_busy = 1'b1;
        mul_fu_busy = 1'b1;
        for (int i = 0; i < 6; i++)
        begin
            drive_dispatch(rs_sel_e'(i % 2), preg_t'(3), 1'b1, preg_t'(4), 1'b1,
                           rob_idx_t'(16 + i), OP_ADD);
            tick();
        end
        idle_inputs();
        sample();
        expect_valid(0, 1'b0);
        expect_valid(1, 1'b0);
        advance();
        add_fu_busy = 1'b0;
        mul_fu_busy = 1'b0;
        for (int k = 0; k < 3; k++)
        begin
            sample();       // order by index comes from the model
            expect_valid(0, 1'b1);
            expect_valid(1, 1'b1);
            advance();
        end
        sample();
        expect_valid(0, 1'b0);
        expect_valid(1, 1'b0);
        advance();
    endtask

    task automatic test_mixed();
        rs_sel_e sel;
        preg_t s1;
        preg_t s2;
        logic r1;
        logic r2;
        rob_idx_t rb;
        fu_op_e o;
        for (int n = 0; n < 60; n++)
        begin
            idle_inputs();
            sel = rs_sel_e'(lfsr_bit());
            if (lfsr_bit() && !model_full(int'(sel)))
            begin
                s1 = preg_t'(48 + lfsr_take(3));    // small tag pool, frequent hits
                r1 = lfsr_bit();
                s2 = preg_t'(48 + lfsr_take(3));
                r2 = lfsr_bit();
                rb = rob_idx_t'(lfsr_take(6));
                o  = fu_op_e'(lfsr_take(3));
                drive_dispatch(sel, s1, r1, s2, r2, rb, o);
                pd = preg_t'(lfsr_take(6));
                rd = areg_t'(lfsr_take(5));
            end
            cdb_add_valid = lfsr_bit();
            cdb_add_tag   = preg_t'(48 + lfsr_take(3));
            cdb_mul_valid = lfsr_bit();
            cdb_mul_tag   = preg_t'(48 + lfsr_take(3));
            add_fu_busy   = (lfsr_take(2) == 32'd0);   // busy about a quarter of cycles
            mul_fu_busy   = (lfsr_take(2) == 32'd0);
            tick();
        end
        idle_inputs();
        add_fu_busy = 1'b0;
        mul_fu_busy = 1'b0;
        repeat (2) tick();
    endtask

    // watchdog
    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles == LIMIT)
        begin
            $display("timeout: tests still running after %0d cycles", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    initial
    begin
        dispatch_valid = 1'b0;
        dispatch_sel   = RS_ADD;
        ps1            = '0;
        ps1_rdy        = 1'b0;
        ps2            = '0;
        ps2_rdy        = 1'b0;
        pd             = '0;
        rd             = '0;
        rob            = '0;
        op             = OP_ADD;
        cdb_add_valid  = 1'b0;
        cdb_add_tag    = '0;
        cdb_mul_valid  = 1'b0;
        cdb_mul_tag    = '0;
        add_fu_busy    = 1'b0;
        mul_fu_busy    = 1'b0;
        lfsr_q         = 32'he3f7_c5f9;
        m_av           = 1'b0;
        m_at           = '0;
        m_mv           = 1'b0;
        m_mt           = '0;
        for (int s = 0; s < 2; s++)
            for (int i = 0; i < MAX_DEPTH; i++)
                m_ent[s][i] = '0;
        wait (rst === 1'b1);
        wait (rst === 1'b0);
        test_direct_issue();
        test_wakeup();
        test_same_cycle_wakeup();
        test_fill();
        test_backpressure();
        test_mixed();
        $display("rs_tb: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule : rs_tb

`default_nettype wire

// File: project.f
+incdir+rtl
rtl/rs_pkg.sv
rtl/issue_select.sv
rtl/rs_bank.sv
rtl/rs_top.sv
bench/tb_clock.sv
bench/rs_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rs_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
